/* Makefile */
# Verilator build and run for the AXI4 memory slave testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_mem_slave
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
EXTRA     ?=
PASS_MSG  ?= All tests passed!

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the simulation output holds the pass message
run: compile
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* files.f */
+incdir+tb
rtl/axi_mem_pkg.sv
rtl/axi_burst_check.sv
rtl/axi_write_path.sv
rtl/axi_read_path.sv
rtl/axi_mem_array.sv
rtl/axi_mem_slave.sv
tb/tb_axi_mem_slave.sv

/* rtl/axi_burst_check.sv */
module axi_burst_check import axi_mem_pkg::*; #(
    parameter int mem_depth     = 1024,
    parameter int max_burst_len = 16
) (
    input  axi_ax_t cmd,
    output logic    burst_err
);

    // Bits of byte offset inside a page
    localparam int page_bits  = $clog2(page_bytes);
    // Byte address to word index shift
    localparam int word_shift = $clog2(strb_width);

    logic [31:0] beats;
    logic [31:0] page_off;
    logic [31:0] burst_bytes;
    logic [31:0] first_word;

    logic cross_page;
    logic past_end;
    logic too_long;
    logic too_wide;

    // Everything widened to 32 bits so that no sum wraps
    always_comb begin
        beats       = {24'd0, cmd.len} + 32'd1;
        page_off    = 32'(cmd.addr[page_bits-1:0]);
        burst_bytes = beats << cmd.size;
        first_word  = 32'(cmd.addr >> word_shift);
    end

    // Last byte of the burst falls into the next page
    assign cross_page = (page_off + burst_bytes) > 32'(page_bytes);
    // Last word lies beyond the array
    assign past_end   = (first_word + beats) > 32'(mem_depth);
    // More beats than the slave supports
    assign too_long   = beats > 32'(max_burst_len);
    // Transfer wider than one word
    assign too_wide   = cmd.size > 3'(max_size);

    assign burst_err = cross_page | past_end | too_long | too_wide;

endmodule

/* rtl/axi_mem_array.sv */
module axi_mem_array import axi_mem_pkg::*; #(
    parameter int mem_depth = 1024
) (
    input  logic                            clk,
    input  logic                            wr_en,
    input  logic [$clog2(mem_depth)-1:0]    wr_idx,
    input  logic [data_width-1:0]           wr_data,
    input  logic [strb_width-1:0]           wr_strb,
    input  logic                            rd_en,
    input  logic [$clog2(mem_depth)-1:0]    rd_idx,
    output logic [data_width-1:0]           rd_data
);

    // Word storage, contents undefined until written
    logic [data_width-1:0] mem [mem_depth];

    // Byte lanes written only where the strobe is set
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < strb_width; i++) begin
                if (wr_strb[i]) mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
    end

    // Registered read, one cycle after rd_en
    // Output keeps its value while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) rd_data <= mem[rd_idx];
    end

endmodule

/* rtl/axi_mem_pkg.sv */
package axi_mem_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------

    // Byte address width on AW and AR
    parameter int addr_width = 16;
    // One word per beat
    parameter int data_width = 32;
    parameter int strb_width = data_width / 8;

    // A burst must stay inside one page of this size
    parameter int page_bytes = 4096;
    // Largest size code the slave accepts, 2 means four bytes
    parameter int max_size = 2;

    // ------------------------------
    // Response codes
    // ------------------------------
    parameter logic [1:0] resp_okay   = 2'b00;
    parameter logic [1:0] resp_slverr = 2'b10;

    // ------------------------------
    // Channel payloads
    // ------------------------------

    // Address command, shared by AW and AR
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
    } axi_ax_t;

    // Write data beat
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
        logic                  last;
    } axi_w_t;

    // Read data beat
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } axi_r_t;

    // Write response on B
    typedef logic [1:0] axi_resp_t;

endpackage

/* rtl/axi_mem_slave.sv */
module axi_mem_slave import axi_mem_pkg::*; #(
    parameter int mem_depth     = 1024,
    parameter int max_burst_len = 16
) (
    input  logic      clk,
    input  logic      ARESTN,
    input  axi_ax_t   aw,
    input  logic      awvalid,
    output logic      awready,
    input  axi_w_t    w,
    input  logic      wvalid,
    output logic      wready,
    output axi_resp_t b,
    output logic      bvalid,
    input  logic      bready,
    input  axi_ax_t   ar,
    input  logic      arvalid,
    output logic      arready,
    output axi_r_t    r,
    output logic      rvalid,
    input  logic      rready
);

    localparam int idx_width = $clog2(mem_depth);

    // ------------------------------
    // Internal wiring
    // ------------------------------
    axi_ax_t               wr_cmd;
    axi_ax_t               rd_cmd;
    logic                  wr_err;
    logic                  rd_err;
    logic                  wr_en;
    logic [idx_width-1:0]  wr_idx;
    logic [data_width-1:0] wr_data;
    logic [strb_width-1:0] wr_strb;
    logic                  rd_en;
    logic [idx_width-1:0]  rd_idx;
    logic [data_width-1:0] rd_data;

    // Write side
    axi_write_path #(.mem_depth(mem_depth)) u_write_path (
        .clk, .ARESTN,
        .aw, .awvalid, .awready,
        .w, .wvalid, .wready,
        .b, .bvalid, .bready,
        .cmd(wr_cmd), .burst_err(wr_err),
        .wr_en, .wr_idx, .wr_data, .wr_strb
    );

    axi_burst_check #(.mem_depth(mem_depth), .max_burst_len(max_burst_len)) u_wr_check (
        .cmd(wr_cmd), .burst_err(wr_err)
    );

    // Read side
    axi_read_path #(.mem_depth(mem_depth)) u_read_path (
        .clk, .ARESTN,
        .ar, .arvalid, .arready,
        .r, .rvalid, .rready,
        .cmd(rd_cmd), .burst_err(rd_err),
        .rd_en, .rd_idx, .rd_data
    );

    axi_burst_check #(.mem_depth(mem_depth), .max_burst_len(max_burst_len)) u_rd_check (
        .cmd(rd_cmd), .burst_err(rd_err)
    );

    // Shared storage, one write and one read port
    axi_mem_array #(.mem_depth(mem_depth)) u_mem (
        .clk,
        .wr_en, .wr_idx, .wr_data, .wr_strb,
        .rd_en, .rd_idx, .rd_data
    );

endmodule

/* rtl/axi_read_path.sv */
module axi_read_path import axi_mem_pkg::*; #(
    parameter int mem_depth = 1024
) (
    input  logic                            clk,
    input  logic                            ARESTN,
    input  axi_ax_t                         ar,
    input  logic                            arvalid,
    output logic                            arready,
    output axi_r_t                          r,
    output logic                            rvalid,
    input  logic                            rready,
    output axi_ax_t                         cmd,
    input  logic                            burst_err,
    output logic                            rd_en,
    output logic [$clog2(mem_depth)-1:0]    rd_idx,
    input  logic [data_width-1:0]           rd_data
);

    localparam int idx_width  = $clog2(mem_depth);
    localparam int word_shift = $clog2(strb_width);

    // st_fetch issues one read, st_beat presents its data
    typedef enum logic [1:0] {
        st_addr,
        st_fetch,
        st_beat
    } rd_state_t;

    rd_state_t            state;
    logic [7:0]           beats_left;
    logic [idx_width-1:0] rd_ptr;
    logic [idx_width-1:0] last_ptr;

    // ------------------------------
    // Handshakes and memory port
    // ------------------------------
    assign arready = (state == st_addr);
    assign rvalid  = (state == st_beat);

    // A refused burst never touches the array
    assign rd_en  = (state == st_fetch) && !burst_err;
    assign rd_idx = rd_ptr;

    // Beat built straight from the array output
    // rd_data holds while rd_en is low, so the beat is stable under stall
    always_comb begin
        r.data = burst_err ? '0 : rd_data;
        r.resp = burst_err ? resp_slverr : resp_okay;
        r.last = (beats_left == 8'd0);
    end

    // FSM and remaining beat count
    always_ff @(posedge clk or negedge ARESTN) begin
        if (!ARESTN) begin
            state      <= st_addr;
            beats_left <= 8'd0;
        end else begin
            case (state)
                st_addr: begin
                    if (arvalid) begin
                        state      <= st_fetch;
                        beats_left <= ar.len;
                    end
                end
                st_fetch: state <= st_beat;
                st_beat: begin
                    if (rready) begin
                        if (r.last) begin
                            state <= st_addr;
                        end else begin
                            state      <= st_fetch;
                            beats_left <= beats_left - 8'd1;
                        end
                    end
                end
                default: state <= st_addr;
            endcase
        end
    end

    // Command and word pointer
    always_ff @(posedge clk) begin
        if (arready && arvalid) begin
            cmd    <= ar;
            rd_ptr <= idx_width'(ar.addr >> word_shift);
        end else if (rvalid && rready) begin
            rd_ptr <= rd_ptr + idx_width'(1);
        end
    end

    // Word the final beat must come from
    assign last_ptr = idx_width'((cmd.addr >> word_shift) + addr_width'(cmd.len));

    // R must not change or vanish while the master stalls
    a_r_hold: assert property (@(posedge clk) disable iff (!ARESTN)
        rvalid && !rready |=> rvalid && $stable(r))
        else $error("rvalid or r changed before rready");

    // last only once the pointer has walked to the final word
    a_rlast_final: assert property (@(posedge clk) disable iff (!ARESTN)
        rvalid && r.last |-> (rd_ptr == last_ptr))
        else $error("r.last raised before the final beat");

endmodule

/* rtl/axi_write_path.sv */
module axi_write_path import axi_mem_pkg::*; #(
    parameter int mem_depth = 1024
) (
    input  logic                            clk,
    input  logic                            ARESTN,
    input  axi_ax_t                         aw,
    input  logic                            awvalid,
    output logic                            awready,
    input  axi_w_t                          w,
    input  logic                            wvalid,
    output logic                            wready,
    output axi_resp_t                       b,
    output logic                            bvalid,
    input  logic                            bready,
    output axi_ax_t                         cmd,
    input  logic                            burst_err,
    output logic                            wr_en,
    output logic [$clog2(mem_depth)-1:0]    wr_idx,
    output logic [data_width-1:0]           wr_data,
    output logic [strb_width-1:0]           wr_strb
);

    localparam int idx_width  = $clog2(mem_depth);
    localparam int word_shift = $clog2(strb_width);

    typedef enum logic [1:0] {
        st_addr,
        st_data,
        st_resp
    } wr_state_t;

    wr_state_t             state;
    logic [7:0]            beat_cnt;
    logic [addr_width-1:0] base_word;
    logic                  final_beat;

    // ------------------------------
    // Channel handshakes
    // ------------------------------

    // Each channel is open in exactly one state
    assign awready = (state == st_addr);
    assign wready  = (state == st_data);
    assign bvalid  = (state == st_resp);

    // Counted by the slave, the master's last bit is not trusted
    assign final_beat = (beat_cnt == cmd.len);

    // ------------------------------
    // Memory write port
    // ------------------------------

    // Low address bits only select a byte inside the first word
    assign base_word = cmd.addr >> word_shift;
    assign wr_idx    = idx_width'(base_word + addr_width'(beat_cnt));
    assign wr_data   = w.data;
    assign wr_strb   = w.strb;
    // Beats of a refused burst are taken but dropped
    assign wr_en     = wready && wvalid && !burst_err;

    // FSM and beat counter
    always_ff @(posedge clk or negedge ARESTN) begin
        if (!ARESTN) begin
            state    <= st_addr;
            beat_cnt <= 8'd0;
        end else begin
            case (state)
                st_addr: begin
                    if (awvalid) begin
                        state    <= st_data;
                        beat_cnt <= 8'd0;
                    end
                end
                st_data: begin
                    if (wvalid) begin
                        beat_cnt <= beat_cnt + 8'd1;
                        if (final_beat) state <= st_resp;
                    end
                end
                st_resp: begin
                    // Back to idle once the master takes B
                    if (bready) state <= st_addr;
                end
                default: state <= st_addr;
            endcase
        end
    end

    // Command and response registers
    always_ff @(posedge clk) begin
        if (awready && awvalid) cmd <= aw;
        // Response decided on the final beat, held through st_resp
        if (wready && wvalid && final_beat) b <= burst_err ? resp_slverr : resp_okay;
    end

    // B must not change or vanish while the master stalls
    a_b_hold: assert property (@(posedge clk) disable iff (!ARESTN)
        bvalid && !bready |=> bvalid && $stable(b))
        else $error("bvalid or b changed before bready");

    // Master's last bit has to match the length from AW
    a_wlast_count: assert property (@(posedge clk) disable iff (!ARESTN)
        wvalid && wready |-> (w.last == final_beat))
        else $error("w.last disagrees with the beat count of the burst");

endmodule

/* tb/axi_mem_bus_tasks.svh */
`ifndef AXI_MEM_BUS_TASKS_SVH
`define AXI_MEM_BUS_TASKS_SVH

// ------------------------------
// Bus level tasks
// ------------------------------

// One clock, then the input drive point just after the edge
task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
endtask

// AW command, returns once the slave has taken it
task automatic send_aw(input axi_ax_t cmd);
    aw      = cmd;
    awvalid = 1'b1;
    while (!awready) next_cycle();
    next_cycle();
    awvalid = 1'b0;
endtask

// AR command, same handshake as AW
task automatic send_ar(input axi_ax_t cmd);
    ar      = cmd;
    arvalid = 1'b1;
    while (!arready) next_cycle();
    next_cycle();
    arvalid = 1'b0;
endtask

// Beats come from wbuf and sbuf, last set on beat len
task automatic send_w(input int len);
    for (int k = 0; k <= len; k++) begin
        w.data = wbuf[k];
        w.strb = sbuf[k];
        w.last = (k == len);
        wvalid = 1'b1;
        while (!wready) next_cycle();
        next_cycle();
    end
    wvalid = 1'b0;
endtask

// B response, bready held low for a random stretch when stalls are on
task automatic recv_b(output axi_resp_t resp);
    int        stall;
    axi_resp_t held;
    stall  = stall_on ? int'(next_rand() % max_stall) : 0;
    bready = 1'b0;
    while (!bvalid) next_cycle();
    held = b;
    // Response must sit still while refused
    repeat (stall) begin
        next_cycle();
        check_eq("bvalid", 64'(bvalid), 64'd1);
        check_eq("b", 64'(b), 64'(held));
    end
    bready = 1'b1;
    resp   = b;
    next_cycle();
    bready = 1'b0;
endtask

// One R beat, with the same stall scheme as B
task automatic recv_r(output axi_r_t beat);
    int     stall;
    axi_r_t held;
    stall  = stall_on ? int'(next_rand() % max_stall) : 0;
    rready = 1'b0;
    while (!rvalid) next_cycle();
    held = r;
    repeat (stall) begin
        next_cycle();
        check_eq("rvalid", 64'(rvalid), 64'd1);
        check_eq("r", 64'(r), 64'(held));
    end
    rready = 1'b1;
    beat   = r;
    next_cycle();
    rready = 1'b0;
endtask

`endif

/* tb/tb_axi_mem_slave.sv */
module tb_axi_mem_slave import axi_mem_pkg::*; ();

    localparam int mem_words    = 512;
    localparam int drive_delay  = 1;
    localparam int reset_cycles = 16;
    localparam int max_stall    = 8;
    // Worst case per burst: 17 beats of fetch, stall and handshake, plus command overhead
    localparam int burst_count    = 24;
    localparam int burst_cycles   = 17 * (3 + max_stall) + 6;
    localparam int timeout_cycles = reset_cycles + burst_count * burst_cycles;

    logic      clk;
    logic      ARESTN;
    axi_ax_t   aw;
    logic      awvalid;
    logic      awready;
    axi_w_t    w;
    logic      wvalid;
    logic      wready;
    axi_resp_t b;
    logic      bvalid;
    logic      bready;
    axi_ax_t   ar;
    logic      arvalid;
    logic      arready;
    axi_r_t    r;
    logic      rvalid;
    logic      rready;

    // Reference model of the array and the write beat buffers
    logic [31:0] shadow [0:mem_words-1];
    logic [31:0] wbuf [0:16];
    logic [3:0]  sbuf [0:16];
    logic        stall_on = 1'b0;
    logic [31:0] lcg_state = 32'h75a7cfff;
    int          cycle_cnt = 0;

    axi_mem_slave #(.mem_depth(mem_words), .max_burst_len(16)) i_dut (
        .clk, .ARESTN,
        .aw, .awvalid, .awready,
        .w, .wvalid, .wready,
        .b, .bvalid, .bready,
        .ar, .arvalid, .arready,
        .r, .rvalid, .rready
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------
    // Checking and stimulus helpers
    // ------------------------------
    task automatic fail_run();
        $display("Test failures found");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_run();
        end
    endtask

    // Numerical Recipes LCG constants
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Old bytes survive where the strobe is clear
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[8*i +: 8] = new_word[8*i +: 8];
        end
        return res;
    endfunction

    task automatic fill_random(input int len, input logic [3:0] strb);
        for (int k = 0; k <= len; k++) begin
            wbuf[k] = next_rand();
            sbuf[k] = strb;
        end
    endtask

    `include "axi_mem_bus_tasks.svh"

    task automatic write_burst(input logic [15:0] addr, input logic [7:0] len,
                               input logic [2:0] size, input axi_resp_t exp_resp);
        axi_ax_t   cmd;
        axi_resp_t resp;
        int        idx;
        cmd.addr = addr;
        cmd.len  = len;
        cmd.size = size;
        send_aw(cmd);
        send_w(int'(len));
        recv_b(resp);
        check_eq("b", 64'(resp), 64'(exp_resp));
        // Refused bursts leave the model alone
        if (exp_resp == resp_okay) begin
            for (int k = 0; k <= int'(len); k++) begin
                idx = int'(addr >> 2) + k;
                shadow[idx] = merge_bytes(shadow[idx], wbuf[k], sbuf[k]);
            end
        end
    endtask

    task automatic read_burst(input logic [15:0] addr, input logic [7:0] len,
                              input logic [2:0] size, input axi_resp_t exp_resp);
        axi_ax_t     cmd;
        axi_r_t      beat;
        logic [31:0] exp_data;
        cmd.addr = addr;
        cmd.len  = len;
        cmd.size = size;
        send_ar(cmd);
        for (int k = 0; k <= int'(len); k++) begin
            recv_r(beat);
            // Error beats carry zero data
            exp_data = (exp_resp == resp_okay) ? shadow[int'(addr >> 2) + k] : 32'd0;
            check_eq("r.data", 64'(beat.data), 64'(exp_data));
            check_eq("r.resp", 64'(beat.resp), 64'(exp_resp));
            check_eq("r.last", 64'(beat.last), 64'(k == int'(len)));
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic reset_and_single_beat();
        check_eq("awready", 64'(awready), 64'd1);
        check_eq("arready", 64'(arready), 64'd1);
        check_eq("bvalid", 64'(bvalid), 64'd0);
        check_eq("rvalid", 64'(rvalid), 64'd0);
        check_eq("wready", 64'(wready), 64'd0);
        fill_random(0, 4'hf);
        write_burst(16'h0010, 8'd0, 3'd2, resp_okay);
        read_burst(16'h0010, 8'd0, 3'd2, resp_okay);
    endtask

    task automatic four_beat_burst();
        fill_random(3, 4'hf);
        write_burst(16'h0040, 8'd3, 3'd2, resp_okay);
        read_burst(16'h0040, 8'd3, 3'd2, resp_okay);
    endtask

    task automatic partial_strobe_write();
        fill_random(0, 4'hf);
        write_burst(16'h0100, 8'd0, 3'd2, resp_okay);
        // Lanes 0 and 2 only
        fill_random(0, 4'b0101);
        write_burst(16'h0100, 8'd0, 3'd2, resp_okay);
        read_burst(16'h0100, 8'd0, 3'd2, resp_okay);
    endtask

    // With 512 words the crossing burst also lies past the end
    // Its beats would alias onto words 0x1fe to 0x001 if they were written
    task automatic page_cross_refused();
        fill_random(1, 4'hf);
        write_burst(16'h07f8, 8'd1, 3'd2, resp_okay);
        fill_random(1, 4'hf);
        write_burst(16'h0000, 8'd1, 3'd2, resp_okay);
        fill_random(3, 4'hf);
        write_burst(16'h0ff8, 8'd3, 3'd2, resp_slverr);
        read_burst(16'h07f8, 8'd1, 3'd2, resp_okay);
        read_burst(16'h0000, 8'd1, 3'd2, resp_okay);
        read_burst(16'h0ff8, 8'd3, 3'd2, resp_slverr);
    endtask

    task automatic illegal_bursts_refused();
        // Ends at word 513
        fill_random(3, 4'hf);
        write_burst(16'h07f8, 8'd3, 3'd2, resp_slverr);
        read_burst(16'h07f8, 8'd3, 3'd2, resp_slverr);
        // 17 beats
        fill_random(16, 4'hf);
        write_burst(16'h0000, 8'd16, 3'd2, resp_slverr);
        read_burst(16'h0000, 8'd16, 3'd2, resp_slverr);
        // Eight byte transfer
        fill_random(0, 4'hf);
        write_burst(16'h0000, 8'd0, 3'd3, resp_slverr);
        read_burst(16'h0000, 8'd0, 3'd3, resp_slverr);
        read_burst(16'h0000, 8'd1, 3'd2, resp_okay);
    endtask

    task automatic backpressure_hold();
        stall_on = 1'b1;
        fill_random(7, 4'hf);
        write_burst(16'h0200, 8'd7, 3'd2, resp_okay);
        read_burst(16'h0200, 8'd7, 3'd2, resp_okay);
        // Longest legal burst
        fill_random(15, 4'hf);
        write_burst(16'h0000, 8'd15, 3'd2, resp_okay);
        read_burst(16'h0000, 8'd15, 3'd2, resp_okay);
        stall_on = 1'b0;
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == timeout_cycles) begin
            $display("Timeout: tests did not finish within %0d cycles", timeout_cycles);
            fail_run();
        end
    end

    initial begin
        ARESTN  = 1'b0;
        aw      = '0;
        awvalid = 1'b0;
        w       = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        ar      = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        ARESTN = 1'b1;
        reset_and_single_beat();
        four_beat_burst();
        partial_strobe_write();
        page_cross_refused();
        illegal_bursts_refused();
        backpressure_hold();
        $display("All tests passed!");
        $finish;
    end

endmodule
